// ==== common/sched_cfg_pkg.sv ====
package sched_cfg_pkg;

    // bank geometry
    localparam int BANK_GROUPS     = 2;
    localparam int BANKS_PER_GROUP = 2;
    localparam int BANKS           = BANK_GROUPS * BANKS_PER_GROUP;
    localparam int BG_BITS         = $clog2(BANK_GROUPS);
    localparam int BANK_BITS       = $clog2(BANKS_PER_GROUP);
    localparam int BANK_IDX_BITS   = BG_BITS + BANK_BITS;  // flat bank number {group, bank}

    // address and data widths
    localparam int ROW_BITS  = 8;
    localparam int COL_BITS  = 4;
    localparam int DATA_BITS = 32;

    // per-bank request queue, depth kept a power of two so pointers wrap
    localparam int QUEUE_DEPTH = 4;
    localparam int PTR_BITS    = $clog2(QUEUE_DEPTH);
    localparam int CNT_BITS    = $clog2(QUEUE_DEPTH + 1);

    // DRAM latencies in controller cycles
    localparam int ACT_LATENCY = 8;  // ACT to RD/WR on the same bank
    localparam int PRE_LATENCY = 5;  // PRE to ACT on the same bank
    localparam int TIMER_BITS  =
        $clog2(ACT_LATENCY > PRE_LATENCY ? ACT_LATENCY : PRE_LATENCY);

endpackage

// ==== common/sched_cmd_pkg.sv ====
package sched_cmd_pkg;

    // encoding seen by the memory controller
    typedef enum logic [2:0] {
        CMD_READ      = 3'd0,
        CMD_WRITE     = 3'd1,
        CMD_ACTIVATE  = 3'd2,
        CMD_PRECHARGE = 3'd3
    } dram_cmd_e;

    typedef enum logic [1:0] {
        BANK_CLOSED,
        BANK_PRECHARGING,
        BANK_ACTIVATING,
        BANK_OPEN
    } bank_state_e;

    // one queued request, group and bank are implied by the queue it sits in
    typedef struct packed {
        logic [sched_cfg_pkg::ROW_BITS-1:0]  row;
        logic [sched_cfg_pkg::COL_BITS-1:0]  col;
        logic                                write;
        logic [sched_cfg_pkg::DATA_BITS-1:0] data;
    } mem_request_t;

endpackage

// ==== common/bank_cmd_if.sv ====
interface bank_cmd_if;

    logic                                want;   // level request, held until granted
    sched_cmd_pkg::dram_cmd_e            cmd;
    logic [sched_cfg_pkg::ROW_BITS-1:0]  row;
    logic [sched_cfg_pkg::COL_BITS-1:0]  col;
    logic [sched_cfg_pkg::DATA_BITS-1:0] data;
    logic                                grant;  // command taken this cycle

    modport engine (
        output want, cmd, row, col, data,
        input  grant
    );

    modport arbiter (
        input  want, cmd, row, col, data,
        output grant
    );

endinterface

// ==== bank_engine/bank_req_fifo.sv ====
module bank_req_fifo (
    input  logic                        clk_in,
    input  logic                        rst_in,
    input  logic                        push,
    input  sched_cmd_pkg::mem_request_t push_req,
    input  logic                        pop,
    output sched_cmd_pkg::mem_request_t head,
    output logic                        empty
);

    sched_cmd_pkg::mem_request_t mem [sched_cfg_pkg::QUEUE_DEPTH];

    logic [sched_cfg_pkg::PTR_BITS-1:0] wr_ptr;
    logic [sched_cfg_pkg::PTR_BITS-1:0] rd_ptr;
    logic [sched_cfg_pkg::CNT_BITS-1:0] count;
    logic                               full;

    assign empty = (count == '0);
    assign full  = (count == sched_cfg_pkg::CNT_BITS'(sched_cfg_pkg::QUEUE_DEPTH));
    assign head  = mem[rd_ptr];  // oldest entry, valid when !empty

    always_ff @(posedge clk_in or posedge rst_in) begin
        if (rst_in) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= wr_ptr + 1'b1;  // wraps at depth
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;  // none, or push and pop together
            endcase
        end
    end

    // storage
    always_ff @(posedge clk_in) begin
        if (push) begin
            mem[wr_ptr] <= push_req;
        end
    end

    // the input has no back-pressure, so an overflow would silently drop a request
    a_no_overflow: assert property (
        @(posedge clk_in) disable iff (rst_in)
        push |-> !full
    ) else $error("bank queue overflow");

    // the engine only pops on a granted access, which needs a head entry
    a_no_underflow: assert property (
        @(posedge clk_in) disable iff (rst_in)
        pop |-> !empty
    ) else $error("bank queue underflow");

endmodule

// ==== bank_engine/bank_engine.sv ====
module bank_engine (
    input  logic                        clk_in,
    input  logic                        rst_in,
    input  logic                        empty,
    input  sched_cmd_pkg::mem_request_t head,
    output logic                        pop,
    bank_cmd_if.engine                  port
);

    sched_cmd_pkg::bank_state_e              state;
    logic [sched_cfg_pkg::ROW_BITS-1:0]      open_row;
    logic [sched_cfg_pkg::TIMER_BITS-1:0]    timer;
    logic                                    row_hit;
    logic                                    access_grant;

    assign row_hit = (head.row == open_row);

    // fields always follow the head, want and cmd say whether they matter
    assign port.row  = head.row;
    assign port.col  = head.col;
    assign port.data = head.data;

    // next command needed by the head request
    always_comb begin
        port.want = 1'b0;
        port.cmd  = sched_cmd_pkg::CMD_READ;
        if (!empty) begin
            case (state)
                sched_cmd_pkg::BANK_CLOSED: begin
                    port.want = 1'b1;
                    port.cmd  = sched_cmd_pkg::CMD_ACTIVATE;
                end
                sched_cmd_pkg::BANK_OPEN: begin
                    port.want = 1'b1;
                    if (!row_hit) begin
                        port.cmd = sched_cmd_pkg::CMD_PRECHARGE;  // row miss
                    end else if (head.write) begin
                        port.cmd = sched_cmd_pkg::CMD_WRITE;
                    end else begin
                        port.cmd = sched_cmd_pkg::CMD_READ;
                    end
                end
                default: ;  // wait for the timer
            endcase
        end
    end

    assign access_grant = port.grant &&
                          (port.cmd == sched_cmd_pkg::CMD_READ ||
                           port.cmd == sched_cmd_pkg::CMD_WRITE);
    assign pop = access_grant;  // request retires with its access

    always_ff @(posedge clk_in or posedge rst_in) begin
        if (rst_in) begin
            state <= sched_cmd_pkg::BANK_CLOSED;
            timer <= '0;
        end else begin
            case (state)
                sched_cmd_pkg::BANK_CLOSED: begin
                    if (port.grant) begin
                        state <= sched_cmd_pkg::BANK_ACTIVATING;
                        timer <= sched_cfg_pkg::TIMER_BITS'(sched_cfg_pkg::ACT_LATENCY - 1);
                    end
                end
                sched_cmd_pkg::BANK_OPEN: begin
                    if (port.grant && port.cmd == sched_cmd_pkg::CMD_PRECHARGE) begin
                        state <= sched_cmd_pkg::BANK_PRECHARGING;
                        timer <= sched_cfg_pkg::TIMER_BITS'(sched_cfg_pkg::PRE_LATENCY - 1);
                    end
                end
                sched_cmd_pkg::BANK_PRECHARGING: begin
                    if (timer == '0) begin
                        state <= sched_cmd_pkg::BANK_CLOSED;
                    end else begin
                        timer <= timer - 1'b1;
                    end
                end
                default: begin  // activating
                    if (timer == '0) begin
                        state <= sched_cmd_pkg::BANK_OPEN;
                    end else begin
                        timer <= timer - 1'b1;
                    end
                end
            endcase
        end
    end

    // row captured with the ACT, only meaningful once open
    always_ff @(posedge clk_in) begin
        if (port.grant && state == sched_cmd_pkg::BANK_CLOSED) begin
            open_row <= head.row;
        end
    end

    // whatever the arbiter grants, an access must land on the open row
    a_access_on_open_row: assert property (
        @(posedge clk_in) disable iff (rst_in)
        access_grant |-> (state == sched_cmd_pkg::BANK_OPEN && !empty && row_hit)
    ) else $error("access granted without its row open");

endmodule

// ==== hw/command_arbiter.sv ====
module command_arbiter (
    input  logic                                    clk_in,
    input  logic                                    rst_in,
    input  logic                                    cmd_ready,
    bank_cmd_if.arbiter                             ports [sched_cfg_pkg::BANKS],
    output logic                                    valid_out,
    output sched_cmd_pkg::dram_cmd_e                cmd_out,
    output logic [sched_cfg_pkg::BG_BITS-1:0]       bank_group_out,
    output logic [sched_cfg_pkg::BANK_BITS-1:0]     bank_out,
    output logic [sched_cfg_pkg::ROW_BITS-1:0]      row_out,
    output logic [sched_cfg_pkg::COL_BITS-1:0]      col_out,
    output logic [sched_cfg_pkg::DATA_BITS-1:0]     val_out
);

    logic [sched_cfg_pkg::BANKS-1:0]         rw_vec;
    logic [sched_cfg_pkg::BANKS-1:0]         act_vec;
    logic [sched_cfg_pkg::BANKS-1:0]         pre_vec;
    logic [sched_cfg_pkg::BANKS-1:0]         class_vec;
    logic [sched_cfg_pkg::BANKS-1:0]         grant_vec;
    sched_cmd_pkg::dram_cmd_e                cmd_arr  [sched_cfg_pkg::BANKS];
    logic [sched_cfg_pkg::ROW_BITS-1:0]      row_arr  [sched_cfg_pkg::BANKS];
    logic [sched_cfg_pkg::COL_BITS-1:0]      col_arr  [sched_cfg_pkg::BANKS];
    logic [sched_cfg_pkg::DATA_BITS-1:0]     data_arr [sched_cfg_pkg::BANKS];
    logic [sched_cfg_pkg::BANK_IDX_BITS-1:0] sel_idx;
    logic                                    sel_valid;

    // flatten the interface array, it can only be indexed by constants
    for (genvar b = 0; b < sched_cfg_pkg::BANKS; b++) begin : g_port
        assign cmd_arr[b]  = ports[b].cmd;
        assign row_arr[b]  = ports[b].row;
        assign col_arr[b]  = ports[b].col;
        assign data_arr[b] = ports[b].data;
        assign rw_vec[b]   = ports[b].want &&
                             (ports[b].cmd == sched_cmd_pkg::CMD_READ ||
                              ports[b].cmd == sched_cmd_pkg::CMD_WRITE);
        assign act_vec[b]  = ports[b].want && ports[b].cmd == sched_cmd_pkg::CMD_ACTIVATE;
        assign pre_vec[b]  = ports[b].want && ports[b].cmd == sched_cmd_pkg::CMD_PRECHARGE;
        assign ports[b].grant = grant_vec[b];

        // an engine keeps its request and fields steady until the grant takes them
        a_want_held: assert property (
            @(posedge clk_in) disable iff (rst_in)
            ports[b].want && !grant_vec[b] |=>
                ports[b].want && $stable(cmd_arr[b]) && $stable(row_arr[b]) &&
                $stable(col_arr[b])
        ) else $error("bank request changed before its grant");
    end

    // rd/wr before act before pre
    assign class_vec = (rw_vec != '0)  ? rw_vec  :
                       (act_vec != '0) ? act_vec : pre_vec;

    always_comb begin
        sel_idx = '0;
        for (int i = sched_cfg_pkg::BANKS - 1; i >= 0; i--) begin
            if (class_vec[i]) begin
                sel_idx = sched_cfg_pkg::BANK_IDX_BITS'(i);  // lowest bank wins
            end
        end
    end

    assign sel_valid = cmd_ready && (class_vec != '0);
    assign grant_vec = sel_valid ? (sched_cfg_pkg::BANKS'(1) << sel_idx) : '0;

    always_ff @(posedge clk_in or posedge rst_in) begin
        if (rst_in) begin
            valid_out <= 1'b0;
            cmd_out   <= sched_cmd_pkg::CMD_READ;
        end else begin
            valid_out <= sel_valid;  // one pulse per granted command
            if (sel_valid) begin
                cmd_out <= cmd_arr[sel_idx];
            end
        end
    end

    always_ff @(posedge clk_in) begin
        if (sel_valid) begin
            bank_group_out <= sel_idx[sched_cfg_pkg::BANK_IDX_BITS-1 -: sched_cfg_pkg::BG_BITS];
            bank_out       <= sel_idx[sched_cfg_pkg::BANK_BITS-1:0];
            row_out        <= row_arr[sel_idx];
            col_out        <= col_arr[sel_idx];
            val_out        <= (cmd_arr[sel_idx] == sched_cmd_pkg::CMD_WRITE) ?
                              data_arr[sel_idx] : '0;
        end
    end

endmodule

// ==== hw/request_scheduler.sv ====
module request_scheduler (
    input  logic                                    clk_in,
    input  logic                                    rst_in,
    input  logic                                    valid_in,
    input  logic [sched_cfg_pkg::BG_BITS-1:0]       bank_group_in,
    input  logic [sched_cfg_pkg::BANK_BITS-1:0]     bank_in,
    input  logic [sched_cfg_pkg::ROW_BITS-1:0]      row_in,
    input  logic [sched_cfg_pkg::COL_BITS-1:0]      col_in,
    input  logic                                    write_in,
    input  logic [sched_cfg_pkg::DATA_BITS-1:0]     val_in,
    input  logic                                    cmd_ready,  // controller can take a command
    output logic                                    valid_out,
    output sched_cmd_pkg::dram_cmd_e                cmd_out,
    output logic [sched_cfg_pkg::BG_BITS-1:0]       bank_group_out,
    output logic [sched_cfg_pkg::BANK_BITS-1:0]     bank_out,
    output logic [sched_cfg_pkg::ROW_BITS-1:0]      row_out,
    output logic [sched_cfg_pkg::COL_BITS-1:0]      col_out,
    output logic [sched_cfg_pkg::DATA_BITS-1:0]     val_out
);

    logic [sched_cfg_pkg::BANK_IDX_BITS-1:0] req_bank;
    sched_cmd_pkg::mem_request_t             req;

    bank_cmd_if bank_port [sched_cfg_pkg::BANKS] ();

    assign req_bank  = {bank_group_in, bank_in};  // flat bank number
    assign req.row   = row_in;
    assign req.col   = col_in;
    assign req.write = write_in;
    assign req.data  = val_in;

    for (genvar b = 0; b < sched_cfg_pkg::BANKS; b++) begin : g_bank
        logic                        push;
        logic                        pop;
        logic                        empty;
        sched_cmd_pkg::mem_request_t head;

        assign push = valid_in && (req_bank == sched_cfg_pkg::BANK_IDX_BITS'(b));

        bank_req_fifo u_fifo (
            .clk_in   (clk_in),
            .rst_in   (rst_in),
            .push     (push),
            .push_req (req),
            .pop      (pop),
            .head     (head),
            .empty    (empty)
        );

        bank_engine u_engine (
            .clk_in (clk_in),
            .rst_in (rst_in),
            .empty  (empty),
            .head   (head),
            .pop    (pop),
            .port   (bank_port[b])
        );
    end

    command_arbiter u_arbiter (
        .clk_in         (clk_in),
        .rst_in         (rst_in),
        .cmd_ready      (cmd_ready),
        .ports          (bank_port),
        .valid_out      (valid_out),
        .cmd_out        (cmd_out),
        .bank_group_out (bank_group_out),
        .bank_out       (bank_out),
        .row_out        (row_out),
        .col_out        (col_out),
        .val_out        (val_out)
    );

endmodule

// ==== tb/tb_request_scheduler.sv ====
module tb_request_scheduler;

    localparam int TIMEOUT = 6 * 4 * 40;  // tests x requests x cycles per request

    logic                                    clk_in = 1'b0;
    logic                                    rst_in;
    logic                                    valid_in;
    logic [sched_cfg_pkg::BG_BITS-1:0]       bank_group_in;
    logic [sched_cfg_pkg::BANK_BITS-1:0]     bank_in;
    logic [sched_cfg_pkg::ROW_BITS-1:0]      row_in;
    logic [sched_cfg_pkg::COL_BITS-1:0]      col_in;
    logic                                    write_in;
    logic [sched_cfg_pkg::DATA_BITS-1:0]     val_in;
    logic                                    cmd_ready;
    logic                                    valid_out;
    sched_cmd_pkg::dram_cmd_e                cmd_out;
    logic [sched_cfg_pkg::BG_BITS-1:0]       bank_group_out;
    logic [sched_cfg_pkg::BANK_BITS-1:0]     bank_out;
    logic [sched_cfg_pkg::ROW_BITS-1:0]      row_out;
    logic [sched_cfg_pkg::COL_BITS-1:0]      col_out;
    logic [sched_cfg_pkg::DATA_BITS-1:0]     val_out;

    // reference model, one queue and one open row per bank
    sched_cmd_pkg::mem_request_t             exp_q [sched_cfg_pkg::BANKS][$];
    sched_cmd_pkg::mem_request_t             head_req [sched_cfg_pkg::BANKS];
    logic                                    head_valid [sched_cfg_pkg::BANKS];
    logic                                    bank_open [sched_cfg_pkg::BANKS];
    logic [sched_cfg_pkg::ROW_BITS-1:0]      open_row [sched_cfg_pkg::BANKS];
    int                                      act_cyc [sched_cfg_pkg::BANKS];
    int                                      pre_cyc [sched_cfg_pkg::BANKS];
    int                                      cycles = 0;
    int                                      pending = 0;
    int                                      errors = 0;
    int                                      errors_at_start = 0;
    int                                      passed = 0;
    int                                      failed = 0;
    integer                                  seed;
    logic [31:0]                             rnd;
    string                                   test_name = "reset";
    logic                                    ready_q;  // cmd_ready seen by the last grant

    logic [sched_cfg_pkg::BANK_IDX_BITS-1:0] out_idx;
    sched_cmd_pkg::mem_request_t             exp_req;
    sched_cmd_pkg::dram_cmd_e                exp_cmd;
    logic [sched_cfg_pkg::DATA_BITS-1:0]     exp_val;
    logic                                    is_access;
    logic                                    check;

    request_scheduler dut (.*);

    always #10 clk_in = ~clk_in;

    // expected command for the bank named on the outputs
    assign out_idx   = {bank_group_out, bank_out};
    assign exp_req   = head_req[out_idx];
    assign exp_cmd   = !bank_open[out_idx] ? sched_cmd_pkg::CMD_ACTIVATE :
                       (open_row[out_idx] != exp_req.row) ? sched_cmd_pkg::CMD_PRECHARGE :
                       exp_req.write ? sched_cmd_pkg::CMD_WRITE : sched_cmd_pkg::CMD_READ;
    assign exp_val   = exp_req.write ? exp_req.data : '0;
    assign is_access = (cmd_out == sched_cmd_pkg::CMD_READ || cmd_out == sched_cmd_pkg::CMD_WRITE);
    assign check     = valid_out && head_valid[out_idx];

    always @(posedge clk_in) begin
        cycles <= cycles + 1;
        if (cycles >= TIMEOUT) begin
            $display("timeout after %0d cycles with %0d requests unserved", cycles, pending);
            $display("Regression failed");
            $finish;
        end
    end

    always @(posedge clk_in) begin
        logic [sched_cfg_pkg::BANK_IDX_BITS-1:0] b;
        sched_cmd_pkg::mem_request_t             new_req;
        ready_q <= cmd_ready;
        if (rst_in) begin
            for (int i = 0; i < sched_cfg_pkg::BANKS; i++) begin
                exp_q[i].delete();
                bank_open[i] = 1'b0;
                open_row[i]  = '0;
                act_cyc[i]   = -100;
                pre_cyc[i]   = -100;
            end
            pending = 0;
        end else begin
            if (valid_out) begin
                b = {bank_group_out, bank_out};
                case (cmd_out)
                    sched_cmd_pkg::CMD_ACTIVATE: begin
                        bank_open[b] = 1'b1;
                        open_row[b]  = row_out;
                        act_cyc[b]   = cycles;
                    end
                    sched_cmd_pkg::CMD_PRECHARGE: begin
                        bank_open[b] = 1'b0;
                        pre_cyc[b]   = cycles;
                    end
                    default: begin
                        if (exp_q[b].size() > 0) begin
                            void'(exp_q[b].pop_front());  // access retires the request
                            pending--;
                        end
                    end
                endcase
            end
            if (valid_in) begin
                new_req.row   = row_in;
                new_req.col   = col_in;
                new_req.write = write_in;
                new_req.data  = val_in;
                exp_q[{bank_group_in, bank_in}].push_back(new_req);
                pending++;
            end
        end
        for (int i = 0; i < sched_cfg_pkg::BANKS; i++) begin
            head_valid[i] = (exp_q[i].size() > 0);
            head_req[i]   = head_valid[i] ? exp_q[i][0] : '0;
        end
    end

    // outputs and model settle after the rising edge, so check on the falling one
    a_pending: assert property (@(negedge clk_in) disable iff (rst_in)
        valid_out |-> head_valid[out_idx])
        else begin
            errors++;
            $display("%s: command issued for bank %0d with no request pending", test_name, out_idx);
        end

    a_cmd: assert property (@(negedge clk_in) disable iff (rst_in) check |-> cmd_out == exp_cmd)
        else begin
            errors++;
            $display("[FAIL] %s: cmd expected %0d actual %0d", test_name, exp_cmd, cmd_out);
        end

    a_row: assert property (@(negedge clk_in) disable iff (rst_in)
        check && cmd_out != sched_cmd_pkg::CMD_PRECHARGE |-> row_out == exp_req.row)
        else begin
            errors++;
            $display("[FAIL] %s: row expected %0h actual %0h", test_name, exp_req.row, row_out);
        end

    a_col: assert property (@(negedge clk_in) disable iff (rst_in)
        check && is_access |-> col_out == exp_req.col)
        else begin
            errors++;
            $display("[FAIL] %s: col expected %0h actual %0h", test_name, exp_req.col, col_out);
        end

    a_val: assert property (@(negedge clk_in) disable iff (rst_in)
        check && is_access |-> val_out == exp_val)
        else begin
            errors++;
            $display("[FAIL] %s: data expected %0h actual %0h", test_name, exp_val, val_out);
        end

    a_act_gap: assert property (@(negedge clk_in) disable iff (rst_in)
        valid_out && is_access |-> cycles - act_cyc[out_idx] >= sched_cfg_pkg::ACT_LATENCY)
        else begin
            errors++;
            $display("[FAIL] %s: act gap expected >= %0d actual %0d", test_name,
                     sched_cfg_pkg::ACT_LATENCY, cycles - act_cyc[out_idx]);
        end

    a_pre_gap: assert property (@(negedge clk_in) disable iff (rst_in)
        valid_out && cmd_out == sched_cmd_pkg::CMD_ACTIVATE |->
        cycles - pre_cyc[out_idx] >= sched_cfg_pkg::PRE_LATENCY)
        else begin
            errors++;
            $display("[FAIL] %s: pre gap expected >= %0d actual %0d", test_name,
                     sched_cfg_pkg::PRE_LATENCY, cycles - pre_cyc[out_idx]);
        end

    a_stall: assert property (@(negedge clk_in) disable iff (rst_in) !ready_q |-> !valid_out)
        else begin
            errors++;
            $display("%s: command issued while cmd_ready was low", test_name);
        end

    task automatic send_req(input int bank, input logic [sched_cfg_pkg::ROW_BITS-1:0] row,
                            input logic [sched_cfg_pkg::COL_BITS-1:0] col, input logic write);
        @(posedge clk_in);
        valid_in      <= 1'b1;
        bank_group_in <= sched_cfg_pkg::BG_BITS'(bank >> sched_cfg_pkg::BANK_BITS);
        bank_in       <= sched_cfg_pkg::BANK_BITS'(bank);
        row_in        <= row;
        col_in        <= col;
        write_in      <= write;
        val_in        <= $random(seed);
        @(posedge clk_in);
        valid_in      <= 1'b0;
    endtask

    task automatic start_test(input string name);
        test_name       = name;
        errors_at_start = errors;
    endtask

    task automatic wait_idle();
        @(negedge clk_in);  // the last push is counted at the rising edge before
        while (pending != 0) @(negedge clk_in);
    endtask

    task automatic finish_test();
        wait_idle();
        repeat (2) @(negedge clk_in);
        if (errors == errors_at_start) begin
            passed++;
            $display("test %-14s ok", test_name);
        end else begin
            failed++;
            $display("test %-14s FAILED with %0d errors", test_name, errors - errors_at_start);
        end
    endtask

    initial begin
        rst_in        = 1'b1;
        valid_in      = 1'b0;
        bank_group_in = '0;
        bank_in       = '0;
        row_in        = '0;
        col_in        = '0;
        write_in      = 1'b0;
        val_in        = '0;
        cmd_ready     = 1'b1;
        seed          = 32'h4aa1_be66;
        repeat (5) @(posedge clk_in);
        rst_in <= 1'b0;

        start_test("first_access");
        repeat (10) @(posedge clk_in);  // idle, nothing may come out
        send_req(0, 8'h12, 4'h3, 1'b0);
        finish_test();

        start_test("row_hit");
        send_req(0, 8'h12, 4'h5, 1'b1);
        send_req(0, 8'h12, 4'h9, 1'b0);
        finish_test();

        start_test("row_miss");
        send_req(0, 8'h34, 4'h1, 1'b1);
        finish_test();

        start_test("latency");
        send_req(3, 8'h56, 4'h2, 1'b0);
        wait_idle();
        send_req(3, 8'h78, 4'h7, 1'b1);  // miss on bank 3, PRE then ACT
        finish_test();

        start_test("interleave");
        for (int i = 0; i < 8; i++) begin
            rnd = $random(seed);
            send_req(i % 4, rnd[sched_cfg_pkg::ROW_BITS-1:0], 4'(i), rnd[31]);
        end
        finish_test();

        start_test("back_pressure");
        @(posedge clk_in);
        cmd_ready <= 1'b0;
        for (int i = 0; i < 4; i++) begin
            rnd = $random(seed);
            send_req(3 - i, rnd[sched_cfg_pkg::ROW_BITS-1:0], rnd[7:4], rnd[0]);
        end
        repeat (30) @(posedge clk_in);
        cmd_ready <= 1'b1;
        finish_test();

        $display("%0d tests, %0d passed, %0d failed, %0d errors",
                 passed + failed, passed, failed, errors);
        if (failed == 0 && errors == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

// ==== vlog.f ====
common/sched_cfg_pkg.sv
common/sched_cmd_pkg.sv
common/bank_cmd_if.sv
bank_engine/bank_req_fifo.sv
bank_engine/bank_engine.sv
hw/command_arbiter.sv
hw/request_scheduler.sv
tb/tb_request_scheduler.sv

// ==== run.sh ====
#!/bin/sh
# build the testbench with Verilator and run it
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_request_scheduler -f vlog.f -o sim_tb
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

output=$(./obj_dir/sim_tb)
status=$?
printf '%s\n' "$output"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if printf '%s\n' "$output" | grep -qx "Regression passed"; then
    exit 0
fi
exit 1
